//--- run.sh
#!/bin/sh
# build and run the stream pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=stream_pipe_tb
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module "$TOP" -o "$TOP"
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Simulation finished: PASS" "$LOG"; then
  echo "run passed"
  exit 0
fi

echo "run failed"
exit 1

//--- sim/stream_pipe_tb.sv
//////////////////////////////
// random byte packets into stream_pipe_top, summaries checked by assertions
// expected records come from a byte level model of the packet rules
//////////////////////////////

`timescale 1ns/100ps

`include "stream_defines.svh"

module stream_pipe_tb import stream_pkg::*; ();

  localparam int PKT_CNT = 40;
  localparam int MAX_LEN = 20;
  localparam int MAX_GAP = 3;
  // every byte with its longest gap, six fold for output stalls, plus drain
  localparam int TIMEOUT_CYCLES = PKT_CNT * MAX_LEN * (MAX_GAP + 1) * 6 + 800;

  logic         i_clk;
  logic         i_rst_n;
  logic         i_byte_val;
  logic [7:0]   i_byte_dat;
  logic         i_byte_last;
  logic         i_byte_err;
  logic         o_byte_rdy;
  logic         o_sum_val;
  pkt_summary_t o_sum;
  logic         i_sum_rdy;

  integer seed;
  // 0 always ready, 1 half the cycles, 2 an eighth of the cycles
  int     rdy_mode;
  int     cycle_cnt;
  int     sum_cnt;
  int     mismatch_cnt;
  int     fail_cnt;

  // reference model
  pkt_summary_t                exp_q[$];
  pkt_summary_t                exp_head;
  logic                        exp_have;
  pkt_summary_t                model_rec;
  logic [`SUM_CNT_BITS-1:0]    model_cnt;
  logic [`SUM_ACC_BITS-1:0]    model_sum;
  logic                        model_err;
  logic [`STREAM_CTL_BITS-1:0] model_seq;

  logic sum_take;

  assign sum_take = o_sum_val & i_sum_rdy;

  stream_pipe_top stream_pipe_top_inst (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_byte_val  (i_byte_val),
    .i_byte_dat  (i_byte_dat),
    .i_byte_last (i_byte_last),
    .i_byte_err  (i_byte_err),
    .o_byte_rdy  (o_byte_rdy),
    .o_sum_val   (o_sum_val),
    .o_sum       (o_sum),
    .i_sum_rdy   (i_sum_rdy)
  );

  always #2 i_clk = ~i_clk;

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic pick_sum_rdy();
    int r;
    r = $random(seed);
    case (rdy_mode)
      0: return 1'b1;
      1: return r[0];
      default: return (r[2:0] == 3'b000);
    endcase
  endfunction

  // one clock with output ready redrawn on every edge
  task automatic next_cycle();
    @(posedge i_clk);
    i_sum_rdy <= pick_sum_rdy();
  endtask

  // byte stays on the link until the packer takes it
  task automatic send_byte(input logic [7:0] dat, input logic last, input logic err,
                           input int gap);
    for (int g = 0; g < gap; g++) begin
      i_byte_val <= 1'b0;
      next_cycle();
    end
    i_byte_val  <= 1'b1;
    i_byte_dat  <= dat;
    i_byte_last <= last;
    i_byte_err  <= err;
    next_cycle();
    while (!o_byte_rdy) begin
      next_cycle();
    end
  endtask

  // err_rate n flags one byte in n on average, 0 flags none
  task automatic send_packet(input int len, input int max_gap, input int err_rate);
    logic [7:0] dat;
    logic       err;
    int         gap;
    for (int b = 0; b < len; b++) begin
      dat = 8'($random(seed));
      err = (err_rate != 0) && (rand_below(err_rate) == 0);
      gap = rand_below(max_gap + 1);
      send_byte(dat, b == len - 1, err, gap);
    end
  endtask

  //////////////////////////////
  // model watching both links
  //////////////////////////////

  always @(posedge i_clk) begin
    if (i_rst_n) begin
      if (sum_take) begin
        sum_cnt <= sum_cnt + 1;
        if (exp_q.size() != 0) begin
          void'(exp_q.pop_front());
        end
      end
      if (i_byte_val && o_byte_rdy) begin
        model_cnt = model_cnt + 1'b1;
        model_sum = model_sum + `SUM_ACC_BITS'(i_byte_dat);
        model_err = model_err | i_byte_err;
        // record is complete once the last byte is taken
        if (i_byte_last) begin
          model_rec.seq      = model_seq;
          model_rec.byte_cnt = model_cnt;
          model_rec.byte_sum = model_sum;
          model_rec.err      = model_err;
          exp_q.push_back(model_rec);
          model_seq = model_seq + 1'b1;
          model_cnt = '0;
          model_sum = '0;
          model_err = 1'b0;
        end
      end
      exp_have <= (exp_q.size() != 0);
      if (exp_q.size() != 0) begin
        exp_head <= exp_q[0];
      end
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  a_reset_idle: assert property (
    @(posedge i_clk) $rose(i_rst_n) |-> (!o_sum_val && o_byte_rdy)
  ) else begin
    fail_cnt++;
    $display("link not idle right after reset");
  end

  a_head_present: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) sum_take |-> exp_have
  ) else begin
    fail_cnt++;
    $display("summary accepted with no packet outstanding");
  end

  a_seq_ok: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (sum_take && exp_have) |-> (o_sum.seq == exp_head.seq)
  ) else begin
    mismatch_cnt++;
    $display("mismatch o_sum.seq got %h expected %h",
             $sampled(o_sum.seq), $sampled(exp_head.seq));
  end

  a_cnt_ok: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (sum_take && exp_have) |-> (o_sum.byte_cnt == exp_head.byte_cnt)
  ) else begin
    mismatch_cnt++;
    $display("mismatch o_sum.byte_cnt got %h expected %h",
             $sampled(o_sum.byte_cnt), $sampled(exp_head.byte_cnt));
  end

  a_sum_ok: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (sum_take && exp_have) |-> (o_sum.byte_sum == exp_head.byte_sum)
  ) else begin
    mismatch_cnt++;
    $display("mismatch o_sum.byte_sum got %h expected %h",
             $sampled(o_sum.byte_sum), $sampled(exp_head.byte_sum));
  end

  a_err_ok: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (sum_take && exp_have) |-> (o_sum.err == exp_head.err)
  ) else begin
    mismatch_cnt++;
    $display("mismatch o_sum.err got %h expected %h",
             $sampled(o_sum.err), $sampled(exp_head.err));
  end

  a_sum_hold: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (o_sum_val && !i_sum_rdy) |=> (o_sum_val && $stable(o_sum))
  ) else begin
    fail_cnt++;
    $display("summary dropped or changed while output was stalled");
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    int   len;
    int   max_gap;
    int   err_rate;
    logic stall_run;
    i_clk        = 1'b0;
    i_rst_n      = 1'b0;
    i_byte_val   = 1'b0;
    i_byte_dat   = '0;
    i_byte_last  = 1'b0;
    i_byte_err   = 1'b0;
    i_sum_rdy    = 1'b0;
    seed         = 32'hd537_0ccc;
    rdy_mode     = 0;
    sum_cnt      = 0;
    mismatch_cnt = 0;
    fail_cnt     = 0;
    exp_head     = '0;
    exp_have     = 1'b0;
    model_cnt    = '0;
    model_sum    = '0;
    model_err    = 1'b0;
    model_seq    = '0;
    repeat (2) @(posedge i_clk);
    i_rst_n <= 1'b1;
    for (int p = 0; p < PKT_CNT; p++) begin
      stall_run = (p >= 16 && p < 32);
      // opening packets run back to back with fixed short and full lengths
      if (p < 5) begin
        case (p)
          0: len = 1;
          1: len = 8;
          2: len = 1;
          3: len = 16;
          default: len = 3;
        endcase
        max_gap  = 0;
        err_rate = (p == 2) ? 1 : 0;
        rdy_mode = 0;
      end else begin
        // short gapless packets under heavy stalls fill every stage up to the byte link
        if (stall_run) begin
          len = 1 + rand_below(2);
        end else begin
          len = 1 + rand_below(MAX_LEN);
        end
        max_gap  = stall_run ? 0 : MAX_GAP;
        err_rate = 24;
        rdy_mode = stall_run ? 2 : 1;
      end
      send_packet(len, max_gap, err_rate);
    end
    i_byte_val  <= 1'b0;
    i_byte_last <= 1'b0;
    rdy_mode = 0;
    while (sum_cnt < PKT_CNT) begin
      next_cycle();
    end
    // quiet tail would expose a repeated summary
    repeat (20) next_cycle();
    if (sum_cnt != PKT_CNT) begin
      fail_cnt++;
      $display("received %0d summaries instead of %0d", sum_cnt, PKT_CNT);
    end
    if (exp_q.size() != 0) begin
      fail_cnt++;
      $display("%0d expected summaries never arrived", exp_q.size());
    end
    $display("error counts: mismatches %0d, other failures %0d", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // run limit
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge i_clk);
      cycle_cnt++;
    end
    fail_cnt++;
    $display("timeout, run still busy after %0d cycles", TIMEOUT_CYCLES);
    $display("error counts: mismatches %0d, other failures %0d", mismatch_cnt, fail_cnt);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- tb.f
+incdir+verilog
verilog/stream_pkg.sv
verilog/pipeline_slice.sv
verilog/pipeline_chain.sv
verilog/beat_packer.sv
verilog/packet_summarizer.sv
verilog/stream_pipe_top.sv
sim/stream_pipe_tb.sv

//--- verilog/beat_packer.sv
//////////////////////////////
// packs a byte stream into 8 byte beats with framing fields
// bytes above mod in a short eop beat are stale, not zero
//////////////////////////////

`timescale 1ns/100ps

`include "stream_defines.svh"

module beat_packer import stream_pkg::*; (
  input  logic         i_clk,
  input  logic         i_rst_n,
  // byte link in
  input  logic         i_byte_val,
  input  logic [7:0]   i_byte_dat,
  input  logic         i_byte_last,
  input  logic         i_byte_err,
  output logic         o_byte_rdy,
  // beat link out
  output logic         o_beat_val,
  output stream_beat_t o_beat,
  input  logic         i_beat_rdy
);

  // position of the next byte within the beat
  logic [`STREAM_MOD_BITS-1:0]   byte_idx;
  logic [`STREAM_DAT_BYTS*8-1:0] acc_dat;
  logic [`STREAM_DAT_BYTS*8-1:0] nxt_dat;
  // sticky error for the open packet
  logic                          err_acc;
  // next issued beat opens a packet
  logic                          sop_pend;
  logic [`STREAM_CTL_BITS-1:0]   seq;

  logic         beat_val;
  stream_beat_t beat_q;

  logic byte_acc;
  logic beat_done;
  logic beat_take;

  assign o_beat_val = beat_val;
  assign o_beat     = beat_q;

  assign beat_take = beat_val & i_beat_rdy;
  // held low only while a finished beat is still waiting
  assign o_byte_rdy = ~beat_val | i_beat_rdy;
  assign byte_acc   = i_byte_val & o_byte_rdy;

  // beat closes on its 8th byte or on the packet's last byte
  assign beat_done = byte_acc &
    (i_byte_last | (byte_idx == `STREAM_MOD_BITS'(`STREAM_DAT_BYTS - 1)));

  // current beat contents with the incoming byte dropped in
  always_comb begin
    nxt_dat = acc_dat;
    nxt_dat[byte_idx*8 +: 8] = i_byte_dat;
  end

  //////////////////////////////
  // framing state
  //////////////////////////////

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      beat_val <= 1'b0;
      byte_idx <= '0;
      err_acc  <= 1'b0;
      sop_pend <= 1'b1;
      seq      <= '0;
    end else begin
      if (beat_done) begin
        beat_val <= 1'b1;
      end else if (beat_take) begin
        beat_val <= 1'b0;
      end
      if (byte_acc) begin
        byte_idx <= beat_done ? '0 : byte_idx + 1'b1;
        // error is collected per packet, cleared on last
        err_acc  <= i_byte_last ? 1'b0 : (err_acc | i_byte_err);
        if (beat_done) begin
          sop_pend <= i_byte_last;
        end
        if (i_byte_last) begin
          seq <= seq + 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // beat payload
  //////////////////////////////

  always_ff @(posedge i_clk) begin
    if (byte_acc) begin
      acc_dat[byte_idx*8 +: 8] <= i_byte_dat;
    end
    if (beat_done) begin
      beat_q.dat <= nxt_dat;
      beat_q.sop <= sop_pend;
      beat_q.eop <= i_byte_last;
      beat_q.err <= err_acc | i_byte_err;
      // idx 7 wraps to 0, which marks a full beat
      beat_q.mod <= byte_idx + 1'b1;
      beat_q.ctl <= seq;
    end
  end

  // every freshly issued beat follows an accepted byte
  a_no_empty_beat: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (o_beat_val && (!$past(o_beat_val) || $past(i_beat_rdy)))
      |-> $past(i_byte_val && o_byte_rdy)
  ) else $error("beat_packer issued a beat with no bytes");

endmodule

//--- verilog/packet_summarizer.sv
//////////////////////////////
// reduces each packet to one summary record
// input stalls while a summary is held and not taken
//////////////////////////////

`timescale 1ns/100ps

`include "stream_defines.svh"

module packet_summarizer import stream_pkg::*; (
  input  logic         i_clk,
  input  logic         i_rst_n,
  // beat link in
  input  logic         i_beat_val,
  input  stream_beat_t i_beat,
  output logic         o_beat_rdy,
  // summary link out
  output logic         o_sum_val,
  output pkt_summary_t o_sum,
  input  logic         i_sum_rdy
);

  // running totals for the open packet
  logic [`SUM_CNT_BITS-1:0] cnt_acc;
  logic [`SUM_ACC_BITS-1:0] sum_acc;
  // next accepted beat should open a packet
  logic                     expect_sop;

  logic [`STREAM_MOD_BITS:0] n_valid;
  logic [`SUM_ACC_BITS-1:0]  beat_sum;

  logic         sum_val;
  pkt_summary_t sum_q;
  logic         beat_acc;
  logic         sum_load;

  assign o_sum_val  = sum_val;
  assign o_sum      = sum_q;
  assign o_beat_rdy = ~sum_val | i_sum_rdy;
  assign beat_acc   = i_beat_val & o_beat_rdy;
  assign sum_load   = beat_acc & i_beat.eop;

  // valid bytes in this beat and their sum
  always_comb begin
    if (i_beat.eop && (i_beat.mod != '0)) begin
      n_valid = {1'b0, i_beat.mod};
    end else begin
      n_valid = (`STREAM_MOD_BITS + 1)'(`STREAM_DAT_BYTS);
    end
    beat_sum = '0;
    for (int k = 0; k < `STREAM_DAT_BYTS; k++) begin
      if (k < n_valid) begin
        beat_sum = beat_sum + `SUM_ACC_BITS'(i_beat.dat[k*8 +: 8]);
      end
    end
  end

  //////////////////////////////
  // accumulators
  //////////////////////////////

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      sum_val    <= 1'b0;
      cnt_acc    <= '0;
      sum_acc    <= '0;
      expect_sop <= 1'b1;
    end else begin
      if (sum_load) begin
        sum_val <= 1'b1;
      end else if (i_sum_rdy) begin
        sum_val <= 1'b0;
      end
      if (beat_acc) begin
        expect_sop <= i_beat.eop;
        // eop totals go to the record, start over for the next packet
        cnt_acc <= i_beat.eop ? '0 : cnt_acc + n_valid;
        sum_acc <= i_beat.eop ? '0 : sum_acc + beat_sum;
      end
    end
  end

  // summary record, only written on an accepted eop beat
  always_ff @(posedge i_clk) begin
    if (sum_load) begin
      sum_q.seq      <= i_beat.ctl;
      sum_q.byte_cnt <= cnt_acc + n_valid;
      sum_q.byte_sum <= sum_acc + beat_sum;
      sum_q.err      <= i_beat.err;
    end
  end

  // sop appears exactly on the first beat after an eop
  a_sop_after_eop: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    beat_acc |-> (i_beat.sop == expect_sop)
  ) else $error("packet_summarizer saw bad sop framing");

endmodule

//--- verilog/pipeline_chain.sv
//////////////////////////////
// NUM_STAGES slices in series, latency equals NUM_STAGES
// depth 0 gives a combinational pass through with no registers
//////////////////////////////

`timescale 1ns/100ps

module pipeline_chain #(
  parameter type T          = logic [7:0],
  parameter int  NUM_STAGES = 1
) (
  input  logic i_clk,
  input  logic i_rst_n,
  // upstream side
  input  logic i_val,
  input  T     i_dat,
  output logic o_rdy,
  // downstream side
  output logic o_val,
  output T     o_dat,
  input  logic i_rdy
);

  generate
    if (NUM_STAGES == 0) begin : g_wire

      // no stages, link goes straight across
      assign o_val = i_val;
      assign o_dat = i_dat;
      assign o_rdy = i_rdy;

    end else begin : g_pipe

      // link k feeds stage k, link NUM_STAGES is the output
      logic [NUM_STAGES:0] stg_val;
      logic [NUM_STAGES:0] stg_rdy;
      T                    stg_dat [NUM_STAGES:0];

      assign stg_val[0] = i_val;
      assign stg_dat[0] = i_dat;
      assign o_rdy      = stg_rdy[0];

      for (genvar g = 0; g < NUM_STAGES; g++) begin : g_stage
        pipeline_slice #(
          .T (T)
        ) pipeline_slice_inst (
          .i_clk   (i_clk),
          .i_rst_n (i_rst_n),
          .i_val   (stg_val[g]),
          .i_dat   (stg_dat[g]),
          .o_rdy   (stg_rdy[g]),
          .o_val   (stg_val[g+1]),
          .o_dat   (stg_dat[g+1]),
          .i_rdy   (stg_rdy[g+1])
        );
      end

      assign o_val               = stg_val[NUM_STAGES];
      assign o_dat               = stg_dat[NUM_STAGES];
      assign stg_rdy[NUM_STAGES] = i_rdy;

    end
  endgenerate

endmodule

//--- verilog/pipeline_slice.sv
//////////////////////////////
// one register stage on a val/rdy link, full throughput
// o_rdy comes from a flop, so a stalled beat lands in the skid entry
//////////////////////////////

`timescale 1ns/100ps

module pipeline_slice #(
  parameter type T = logic [7:0]
) (
  input  logic i_clk,
  input  logic i_rst_n,
  // upstream side
  input  logic i_val,
  input  T     i_dat,
  output logic o_rdy,
  // downstream side
  output logic o_val,
  output T     o_dat,
  input  logic i_rdy
);

  // main entry drives the output, skid entry catches one extra beat
  logic main_val;
  logic skid_val;
  T     main_dat;
  T     skid_dat;

  logic in_acc;
  logic main_load;

  // ready only while the skid entry is free, purely from a flop
  assign o_rdy = ~skid_val;
  assign o_val = main_val;
  assign o_dat = main_dat;

  assign in_acc = i_val & o_rdy;

  // main entry can take new data when empty or being drained
  assign main_load = ~main_val | i_rdy;

  //////////////////////////////
  // occupancy flags
  //////////////////////////////

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      main_val <= 1'b0;
      skid_val <= 1'b0;
    end else begin
      if (main_load) begin
        // refill from skid first, upstream is held off meanwhile
        if (skid_val) begin
          main_val <= 1'b1;
          skid_val <= 1'b0;
        end else begin
          main_val <= in_acc;
        end
      end else if (in_acc) begin
        // output stalled, park the incoming beat
        skid_val <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // payload registers
  //////////////////////////////

  always_ff @(posedge i_clk) begin
    if (main_load) begin
      main_dat <= skid_val ? skid_dat : i_dat;
    end
    // skid only captures while main is stuck and skid is empty
    if (!main_load && !skid_val) begin
      skid_dat <= i_dat;
    end
  end

  // a presented beat must not change or vanish until taken
  a_out_hold: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (o_val && !i_rdy) |=> (o_val && $stable(o_dat))
  ) else $error("pipeline_slice output changed while stalled");

endmodule

//--- verilog/stream_defines.svh
//////////////////////////////
// widths and depths shared by the stream pipeline
// beat width must stay 8 bytes while the mod field is 3 bits wide
//////////////////////////////

`ifndef STREAM_DEFINES_SVH
`define STREAM_DEFINES_SVH

// bytes per beat on every beat link
`define STREAM_DAT_BYTS 8

// control field width, carries the packet sequence number
`define STREAM_CTL_BITS 8

// modulo field, holds valid bytes of an eop beat with 0 meaning all
`define STREAM_MOD_BITS 3

// default number of register slices between packer and summarizer
`define STREAM_PIPE_STAGES 2

// summary record field widths
`define SUM_CNT_BITS 16
`define SUM_ACC_BITS 16

`endif

//--- verilog/stream_pipe_top.sv
//////////////////////////////
// packer, slice chain, summarizer and output slice in a row
// no stall latency from last byte to summary is stages + 3
//////////////////////////////

`timescale 1ns/100ps

`include "stream_defines.svh"

module stream_pipe_top import stream_pkg::*; (
  input  logic         i_clk,
  input  logic         i_rst_n,
  // byte link in
  input  logic         i_byte_val,
  input  logic [7:0]   i_byte_dat,
  input  logic         i_byte_last,
  input  logic         i_byte_err,
  output logic         o_byte_rdy,
  // summary link out
  output logic         o_sum_val,
  output pkt_summary_t o_sum,
  input  logic         i_sum_rdy
);

  // packer to chain
  logic         pk_val;
  logic         pk_rdy;
  stream_beat_t pk_beat;
  // chain to summarizer
  logic         ch_val;
  logic         ch_rdy;
  stream_beat_t ch_beat;
  // summarizer to output slice
  logic         sm_val;
  logic         sm_rdy;
  pkt_summary_t sm_sum;

  beat_packer beat_packer_inst (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_byte_val  (i_byte_val),
    .i_byte_dat  (i_byte_dat),
    .i_byte_last (i_byte_last),
    .i_byte_err  (i_byte_err),
    .o_byte_rdy  (o_byte_rdy),
    .o_beat_val  (pk_val),
    .o_beat      (pk_beat),
    .i_beat_rdy  (pk_rdy)
  );

  // long haul beat path
  pipeline_chain #(
    .T          (stream_beat_t),
    .NUM_STAGES (`STREAM_PIPE_STAGES)
  ) pipeline_chain_inst (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_val   (pk_val),
    .i_dat   (pk_beat),
    .o_rdy   (pk_rdy),
    .o_val   (ch_val),
    .o_dat   (ch_beat),
    .i_rdy   (ch_rdy)
  );

  packet_summarizer packet_summarizer_inst (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_beat_val (ch_val),
    .i_beat     (ch_beat),
    .o_beat_rdy (ch_rdy),
    .o_sum_val  (sm_val),
    .o_sum      (sm_sum),
    .i_sum_rdy  (sm_rdy)
  );

  // registers the summary link toward the outside
  pipeline_slice #(
    .T (pkt_summary_t)
  ) pipeline_slice_inst (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_val   (sm_val),
    .i_dat   (sm_sum),
    .o_rdy   (sm_rdy),
    .o_val   (o_sum_val),
    .o_dat   (o_sum),
    .i_rdy   (i_sum_rdy)
  );

endmodule

//--- verilog/stream_pkg.sv
//////////////////////////////
// payload types for the beat links and the summary link
// field widths come from the shared defines header
//////////////////////////////

`include "stream_defines.svh"

package stream_pkg;

  //////////////////////////////
  // beat link payload
  //////////////////////////////

  typedef struct packed {
    // byte 0 sits in the low bits
    logic [`STREAM_DAT_BYTS*8-1:0] dat;
    // first beat of a packet
    logic                          sop;
    // last beat of a packet
    logic                          eop;
    // packet error, only meaningful on eop
    logic                          err;
    // valid bytes on eop modulo beat size
    logic [`STREAM_MOD_BITS-1:0]   mod;
    // packet sequence number
    logic [`STREAM_CTL_BITS-1:0]   ctl;
  } stream_beat_t;

  //////////////////////////////
  // summary link payload
  //////////////////////////////

  typedef struct packed {
    // copied from the ctl field of the packet
    logic [`STREAM_CTL_BITS-1:0] seq;
    // number of valid bytes in the packet
    logic [`SUM_CNT_BITS-1:0]    byte_cnt;
    // byte sum, wraps at 2^16
    logic [`SUM_ACC_BITS-1:0]    byte_sum;
    // any byte of the packet flagged err
    logic                        err;
  } pkt_summary_t;

endpackage
